/* vram_copy_defines.svh */
// Geometry, queue depth and pixel bit macros of the VRAM copy engine that every file needing them includes
`ifndef VRAM_COPY_DEFINES_SVH
`define VRAM_COPY_DEFINES_SVH

// VRAM of 1024 x 512 pixels held as 16-pixel words
`define VRAM_X_W        10
`define VRAM_Y_W        9
`define PIX_PER_WORD_W  4

// Row in the upper 9 bits and x word index in the lower 6 bits
`define WORD_ADDR_W     15

// Queue depths
// RSP_DEPTH is also the read credit limit
`define RSP_DEPTH       4
`define PIX_DEPTH       4
`define WRQ_DEPTH       2

// Pixel bit forced by set-mask
`define MASK_BIT        15

`endif

/* vram_copy_pkg.sv */
// Shared pixel, word, request and command types of the VRAM copy engine that other files use by scoped name
`include "vram_copy_defines.svh"

package vram_copy_pkg;

    localparam int PIX_PER_WORD = 1 << `PIX_PER_WORD_W;

    typedef logic [15:0]                                pixel_t;
    typedef pixel_t [PIX_PER_WORD-1:0]                  vram_word_t;
    typedef logic [PIX_PER_WORD-1:0]                    pix_mask_t;
    typedef logic [`WORD_ADDR_W-1:0]                    word_addr_t;
    typedef logic [`PIX_PER_WORD_W-1:0]                 pix_idx_t;
    typedef logic [`VRAM_X_W-1:0]                       x_coord_t;
    typedef logic [`VRAM_Y_W-1:0]                       y_coord_t;
    typedef logic [`VRAM_X_W-`PIX_PER_WORD_W-1:0]       x_word_t;

    // One copy request
    // Both sizes count from one
    typedef struct packed {
        x_coord_t           src_x;
        y_coord_t           src_y;
        x_coord_t           dst_x;
        y_coord_t           dst_y;
        logic [`VRAM_X_W:0] width;
        logic [`VRAM_Y_W:0] height;
        logic               set_mask;
    } copy_req_t;

    // Span of pixels within one source word that belong to the copy
    typedef struct packed {
        pix_idx_t first;
        pix_idx_t last;
    } rd_tag_t;

    // Memory port command
    typedef struct packed {
        logic       write;
        word_addr_t addr;
        pix_mask_t  mask;
        vram_word_t data;
    } mem_cmd_t;

endpackage

/* copy_fifo.sv */
// Register-array FIFO with a type parameter payload that serves each queue between copy stages
`timescale 1ns/100ps

module copy_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 2
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic push_i,
    input  T     data_i,
    output logic accept_o,
    output logic valid_o,
    output T     data_o,
    input  logic pop_i
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T                 mem_q [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign accept_o = (count_q != (PTR_W + 1)'(DEPTH));
    assign valid_o  = (count_q != '0);
    assign data_o   = mem_q[rd_ptr_q];
    assign do_push  = push_i & accept_o;
    assign do_pop   = pop_i & valid_o;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr_q <= next_ptr(wr_ptr_q);
            if (do_pop)
                rd_ptr_q <= next_ptr(rd_ptr_q);
            if (do_push && !do_pop)
                count_q <= count_q + 1'b1;
            else if (!do_push && do_pop)
                count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (do_push)
            mem_q[wr_ptr_q] <= data_i;
    end

endmodule

/* vram_copy_read_gen.sv */
// Source side walker that issues word reads under a credit limit and queues each word's pixel span
`timescale 1ns/100ps
`include "vram_copy_defines.svh"

module vram_copy_read_gen (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      start_i,
    input  vram_copy_pkg::copy_req_t  req_i,
    output logic                      rd_cmd_valid_o,
    output vram_copy_pkg::word_addr_t rd_addr_o,
    input  logic                      rd_taken_i,
    input  logic                      rsp_pop_i,
    output logic                      tag_valid_o,
    output vram_copy_pkg::rd_tag_t    tag_o,
    input  logic                      tag_accept_i
);

    localparam int CREDIT_W = $clog2(`RSP_DEPTH) + 1;

    logic                    active_q;
    vram_copy_pkg::y_coord_t y_q;
    logic [`VRAM_Y_W:0]      rows_left_q;
    vram_copy_pkg::x_word_t  wx_q;
    logic [CREDIT_W-1:0]     credit_q;
    logic [`VRAM_X_W:0]      end_x;
    vram_copy_pkg::x_word_t  first_wx;
    vram_copy_pkg::x_word_t  last_wx;
    logic                    row_end;

    // Last source pixel of a row
    assign end_x    = {1'b0, req_i.src_x} + req_i.width - 1'b1;
    assign first_wx = req_i.src_x[`VRAM_X_W-1:`PIX_PER_WORD_W];
    assign last_wx  = end_x[`VRAM_X_W-1:`PIX_PER_WORD_W];
    assign row_end  = (wx_q == last_wx);

    // Only the end words of a row are partial
    assign tag_o.first = (wx_q == first_wx) ? req_i.src_x[`PIX_PER_WORD_W-1:0] : '0;
    assign tag_o.last  = row_end ? end_x[`PIX_PER_WORD_W-1:0] : '1;
    assign tag_valid_o = rd_taken_i;

    // A read needs a free credit and room for its tag
    assign rd_cmd_valid_o = active_q & (credit_q < CREDIT_W'(`RSP_DEPTH)) & tag_accept_i;
    assign rd_addr_o      = {y_q, wx_q};

    // ----------------------------------------
    // Row and word walk
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            active_q    <= 1'b0;
            y_q         <= '0;
            rows_left_q <= '0;
            wx_q        <= '0;
        end
        else if (start_i)
        begin
            active_q    <= 1'b1;
            y_q         <= req_i.src_y;
            rows_left_q <= req_i.height;
            wx_q        <= first_wx;
        end
        else if (rd_taken_i)
        begin
            if (row_end)
            begin
                wx_q        <= first_wx;
                y_q         <= y_q + 1'b1;
                rows_left_q <= rows_left_q - 1'b1;
                active_q    <= (rows_left_q != 1);
            end
            else
            begin
                wx_q <= wx_q + 1'b1;
            end
        end
    end

    // Reads in flight or buffered until unroll pops their word
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            credit_q <= '0;
        else if (rd_taken_i && !rsp_pop_i)
            credit_q <= credit_q + 1'b1;
        else if (!rd_taken_i && rsp_pop_i)
            credit_q <= credit_q - 1'b1;
    end

endmodule

/* vram_copy_unroll.sv */
// Unrolls each returned source word into the single pixels that belong to the copy
`timescale 1ns/100ps

module vram_copy_unroll (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      rsp_valid_i,
    input  vram_copy_pkg::vram_word_t rsp_i,
    input  vram_copy_pkg::rd_tag_t    tag_i,
    output logic                      rsp_pop_o,
    output logic                      pix_valid_o,
    output vram_copy_pkg::pixel_t     pix_o,
    input  logic                      pix_accept_i
);

    logic                    mid_q;
    vram_copy_pkg::pix_idx_t idx_q;
    vram_copy_pkg::pix_idx_t idx;
    logic                    push;
    logic                    last;

    // First pixel of a word comes from its tag
    assign idx  = mid_q ? idx_q : tag_i.first;
    assign last = (idx == tag_i.last);
    assign push = rsp_valid_i & pix_accept_i;

    assign pix_valid_o = rsp_valid_i;
    assign pix_o       = rsp_i[idx];

    // Word and tag leave together after the last pixel
    assign rsp_pop_o = push & last;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            mid_q <= 1'b0;
            idx_q <= '0;
        end
        else if (push)
        begin
            mid_q <= !last;
            idx_q <= idx + 1'b1;
        end
    end

endmodule

/* vram_copy_reroll.sv */
// Destination side walker that packs popped pixels into masked write words for the write queue
`timescale 1ns/100ps
`include "vram_copy_defines.svh"

module vram_copy_reroll (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     start_i,
    input  vram_copy_pkg::copy_req_t req_i,
    input  logic                     pix_valid_i,
    input  vram_copy_pkg::pixel_t    pix_i,
    output logic                     pix_pop_o,
    output logic                     wr_valid_o,
    output vram_copy_pkg::mem_cmd_t  wr_o,
    input  logic                     wr_accept_i,
    output logic                     last_pushed_o
);

    logic                      active_q;
    logic                      full_q;
    vram_copy_pkg::y_coord_t   y_q;
    logic [`VRAM_Y_W:0]        rows_left_q;
    vram_copy_pkg::x_word_t    wx_q;
    vram_copy_pkg::pix_idx_t   idx_q;
    vram_copy_pkg::vram_word_t data_q;
    vram_copy_pkg::pix_mask_t  mask_q;
    logic [`VRAM_X_W:0]        end_x;
    vram_copy_pkg::x_word_t    first_wx;
    vram_copy_pkg::x_word_t    last_wx;
    vram_copy_pkg::pix_idx_t   last_idx;
    vram_copy_pkg::pixel_t     pix;
    logic                      row_end;
    logic                      pop;
    logic                      push;

    // Destination geometry of a row
    assign end_x    = {1'b0, req_i.dst_x} + req_i.width - 1'b1;
    assign first_wx = req_i.dst_x[`VRAM_X_W-1:`PIX_PER_WORD_W];
    assign last_wx  = end_x[`VRAM_X_W-1:`PIX_PER_WORD_W];
    assign row_end  = (wx_q == last_wx);
    assign last_idx = row_end ? end_x[`PIX_PER_WORD_W-1:0] : '1;

    always_comb
    begin
        pix            = pix_i;
        pix[`MASK_BIT] = pix_i[`MASK_BIT] | req_i.set_mask;
    end

    // Pixels are taken only while the word is still open
    assign pop       = active_q & ~full_q & pix_valid_i;
    assign push      = full_q & wr_accept_i;
    assign pix_pop_o = pop;

    assign wr_valid_o    = full_q;
    assign wr_o.write    = 1'b1;
    assign wr_o.addr     = {y_q, wx_q};
    assign wr_o.mask     = mask_q;
    assign wr_o.data     = data_q;
    assign last_pushed_o = push & row_end & (rows_left_q == 1);

    // ----------------------------------------
    // Word builder and destination walk
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            active_q    <= 1'b0;
            full_q      <= 1'b0;
            y_q         <= '0;
            rows_left_q <= '0;
            wx_q        <= '0;
            idx_q       <= '0;
            mask_q      <= '0;
        end
        else if (start_i)
        begin
            active_q    <= 1'b1;
            full_q      <= 1'b0;
            y_q         <= req_i.dst_y;
            rows_left_q <= req_i.height;
            wx_q        <= first_wx;
            idx_q       <= req_i.dst_x[`PIX_PER_WORD_W-1:0];
            mask_q      <= '0;
        end
        else if (pop)
        begin
            mask_q[idx_q] <= 1'b1;
            idx_q         <= idx_q + 1'b1;
            full_q        <= (idx_q == last_idx);
        end
        else if (push)
        begin
            full_q <= 1'b0;
            mask_q <= '0;
            if (row_end)
            begin
                wx_q        <= first_wx;
                idx_q       <= req_i.dst_x[`PIX_PER_WORD_W-1:0];
                y_q         <= y_q + 1'b1;
                rows_left_q <= rows_left_q - 1'b1;
                active_q    <= (rows_left_q != 1);
            end
            else
            begin
                wx_q  <= wx_q + 1'b1;
                idx_q <= '0;
            end
        end
    end

    // Unmasked lanes keep stale data
    always_ff @(posedge clk_i)
    begin
        if (pop)
            data_q[idx_q] <= pix;
    end

endmodule

/* vram_copy_port.sv */
// Copy control FSM and memory port mux that puts reads ahead of queued writes
`timescale 1ns/100ps

module vram_copy_port (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      req_valid_i,
    input  vram_copy_pkg::copy_req_t  req_i,
    output logic                      req_accept_o,
    output logic                      busy_o,
    output logic                      done_o,
    output logic                      start_o,
    output vram_copy_pkg::copy_req_t  active_req_o,
    input  logic                      rd_cmd_valid_i,
    input  vram_copy_pkg::word_addr_t rd_addr_i,
    output logic                      rd_taken_o,
    input  logic                      wr_valid_i,
    input  vram_copy_pkg::mem_cmd_t   wr_i,
    output logic                      wr_pop_o,
    input  logic                      last_pushed_i,
    output logic                      mem_cmd_valid_o,
    output vram_copy_pkg::mem_cmd_t   mem_cmd_o,
    input  logic                      mem_busy_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DONE
    } state_t;

    state_t                   state_q;
    logic                     start_q;
    logic                     last_seen_q;
    logic                     hold_wr_q;
    logic                     rd_sel;
    vram_copy_pkg::copy_req_t active_req_q;

    assign req_accept_o = (state_q == ST_IDLE);
    assign busy_o       = (state_q != ST_IDLE);
    assign done_o       = (state_q == ST_DONE);
    assign start_o      = start_q;
    assign active_req_o = active_req_q;

    // ----------------------------------------
    // Control FSM
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q     <= ST_IDLE;
            start_q     <= 1'b0;
            last_seen_q <= 1'b0;
        end
        else
        begin
            start_q <= 1'b0;
            case (state_q)
                ST_IDLE:
                begin
                    if (req_valid_i)
                    begin
                        state_q     <= ST_RUN;
                        start_q     <= 1'b1;
                        last_seen_q <= 1'b0;
                    end
                end
                ST_RUN:
                begin
                    if (last_pushed_i)
                        last_seen_q <= 1'b1;
                    // Finished once the final word has left the write queue
                    if (last_seen_q && !wr_valid_i)
                        state_q <= ST_DONE;
                end
                default:
                begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (req_valid_i && req_accept_o)
            active_req_q <= req_i;
    end

    // ----------------------------------------
    // Port arbitration
    // ----------------------------------------
    // A stalled write keeps the port until taken so the command never changes under busy
    assign rd_sel          = rd_cmd_valid_i & ~hold_wr_q;
    assign mem_cmd_valid_o = rd_cmd_valid_i | wr_valid_i;
    assign rd_taken_o      = rd_sel & ~mem_busy_i;
    assign wr_pop_o        = ~rd_sel & wr_valid_i & ~mem_busy_i;

    always_comb
    begin
        mem_cmd_o = wr_i;
        if (rd_sel)
        begin
            mem_cmd_o      = '0;
            mem_cmd_o.addr = rd_addr_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            hold_wr_q <= 1'b0;
        else
            hold_wr_q <= ~rd_sel & wr_valid_i & mem_busy_i;
    end

endmodule

/* vram_copy_top.sv */
// Top level of the VRAM block-copy engine joining the stage pipeline to its FIFOs and memory port
`timescale 1ns/100ps
`include "vram_copy_defines.svh"

module vram_copy_top (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      req_valid_i,
    input  vram_copy_pkg::copy_req_t  req_i,
    output logic                      req_accept_o,
    output logic                      busy_o,
    output logic                      done_o,
    output logic                      mem_cmd_valid_o,
    output vram_copy_pkg::mem_cmd_t   mem_cmd_o,
    input  logic                      mem_busy_i,
    input  logic                      mem_rsp_valid_i,
    input  vram_copy_pkg::vram_word_t mem_rsp_i
);

    logic                      start;
    vram_copy_pkg::copy_req_t  active_req;
    logic                      rd_cmd_valid;
    vram_copy_pkg::word_addr_t rd_addr;
    logic                      rd_taken;
    logic                      tag_push;
    vram_copy_pkg::rd_tag_t    tag_in;
    logic                      tag_accept;
    vram_copy_pkg::rd_tag_t    tag_head;
    logic                      rsp_valid;
    vram_copy_pkg::vram_word_t rsp_head;
    logic                      rsp_pop;
    logic                      pix_push;
    vram_copy_pkg::pixel_t     pix_in;
    logic                      pix_accept;
    logic                      pix_valid;
    vram_copy_pkg::pixel_t     pix_head;
    logic                      pix_pop;
    logic                      wq_push;
    vram_copy_pkg::mem_cmd_t   wq_in;
    logic                      wq_accept;
    logic                      wq_valid;
    vram_copy_pkg::mem_cmd_t   wq_head;
    logic                      wq_pop;
    logic                      last_pushed;

    vram_copy_port u_port (
        .clk_i(clk_i), .rst_i(rst_i),
        .req_valid_i(req_valid_i), .req_i(req_i), .req_accept_o(req_accept_o),
        .busy_o(busy_o), .done_o(done_o), .start_o(start), .active_req_o(active_req),
        .rd_cmd_valid_i(rd_cmd_valid), .rd_addr_i(rd_addr), .rd_taken_o(rd_taken),
        .wr_valid_i(wq_valid), .wr_i(wq_head), .wr_pop_o(wq_pop),
        .last_pushed_i(last_pushed), .mem_cmd_valid_o(mem_cmd_valid_o),
        .mem_cmd_o(mem_cmd_o), .mem_busy_i(mem_busy_i)
    );

    vram_copy_read_gen u_read_gen (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(start), .req_i(active_req),
        .rd_cmd_valid_o(rd_cmd_valid), .rd_addr_o(rd_addr), .rd_taken_i(rd_taken),
        .rsp_pop_i(rsp_pop), .tag_valid_o(tag_push), .tag_o(tag_in),
        .tag_accept_i(tag_accept)
    );

    // Every response has a tag queued ahead of it, so the tag head is valid with it
    copy_fifo #(.T(vram_copy_pkg::rd_tag_t), .DEPTH(`RSP_DEPTH)) u_tag_fifo (
        .clk_i(clk_i), .rst_i(rst_i), .push_i(tag_push), .data_i(tag_in),
        .accept_o(tag_accept), .valid_o(), .data_o(tag_head), .pop_i(rsp_pop)
    );

    // Read credits guarantee room for every response
    copy_fifo #(.T(vram_copy_pkg::vram_word_t), .DEPTH(`RSP_DEPTH)) u_rsp_fifo (
        .clk_i(clk_i), .rst_i(rst_i), .push_i(mem_rsp_valid_i), .data_i(mem_rsp_i),
        .accept_o(), .valid_o(rsp_valid), .data_o(rsp_head), .pop_i(rsp_pop)
    );

    vram_copy_unroll u_unroll (
        .clk_i(clk_i), .rst_i(rst_i), .rsp_valid_i(rsp_valid), .rsp_i(rsp_head),
        .tag_i(tag_head), .rsp_pop_o(rsp_pop), .pix_valid_o(pix_push), .pix_o(pix_in),
        .pix_accept_i(pix_accept)
    );

    copy_fifo #(.T(vram_copy_pkg::pixel_t), .DEPTH(`PIX_DEPTH)) u_pix_fifo (
        .clk_i(clk_i), .rst_i(rst_i), .push_i(pix_push), .data_i(pix_in),
        .accept_o(pix_accept), .valid_o(pix_valid), .data_o(pix_head), .pop_i(pix_pop)
    );

    vram_copy_reroll u_reroll (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(start), .req_i(active_req),
        .pix_valid_i(pix_valid), .pix_i(pix_head), .pix_pop_o(pix_pop),
        .wr_valid_o(wq_push), .wr_o(wq_in), .wr_accept_i(wq_accept),
        .last_pushed_o(last_pushed)
    );

    copy_fifo #(.T(vram_copy_pkg::mem_cmd_t), .DEPTH(`WRQ_DEPTH)) u_wr_queue (
        .clk_i(clk_i), .rst_i(rst_i), .push_i(wq_push), .data_i(wq_in),
        .accept_o(wq_accept), .valid_o(wq_valid), .data_o(wq_head), .pop_i(wq_pop)
    );

endmodule

/* tb_vram_model.sv */
// Behavioral VRAM for the copy engine testbench with random busy and in-order delayed read data
`timescale 1ns/100ps
`include "vram_copy_defines.svh"

module tb_vram_model (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      cmd_valid_i,
    input  vram_copy_pkg::mem_cmd_t   cmd_i,
    output logic                      busy_o,
    output logic                      rsp_valid_o,
    output vram_copy_pkg::vram_word_t rsp_o
);

    localparam int WORDS = 1 << `WORD_ADDR_W;

    vram_copy_pkg::vram_word_t mem [WORDS];
    vram_copy_pkg::vram_word_t rsp_data_q [$];
    int                        rsp_due_q [$];
    int                        cycle_q;
    int                        last_due_q;
    int                        due;
    vram_copy_pkg::pix_idx_t   lane;

    initial
    begin
        busy_o      = 1'b0;
        rsp_valid_o = 1'b0;
        rsp_o       = '0;
        cycle_q     = 0;
        last_due_q  = 0;
    end

    always @(posedge clk_i)
    begin
        if (rst_i)
        begin
            busy_o      <= 1'b0;
            rsp_valid_o <= 1'b0;
            cycle_q     = 0;
            last_due_q  = 0;
            rsp_data_q.delete();
            rsp_due_q.delete();
        end
        else
        begin
            cycle_q = cycle_q + 1;
            if (cmd_valid_i && !busy_o)
            begin
                if (cmd_i.write)
                begin
                    for (int l = 0; l < 16; l++)
                    begin
                        lane = vram_copy_pkg::pix_idx_t'(l);
                        if (cmd_i.mask[lane])
                            mem[cmd_i.addr][lane] = cmd_i.data[lane];
                    end
                end
                else
                begin
                    // Random latency that never overtakes an earlier read
                    due = cycle_q + int'($urandom_range(6, 1));
                    if (due <= last_due_q)
                        due = last_due_q + 1;
                    last_due_q = due;
                    rsp_data_q.push_back(mem[cmd_i.addr]);
                    rsp_due_q.push_back(due);
                end
            end
            rsp_valid_o <= 1'b0;
            if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle_q)
            begin
                rsp_valid_o <= 1'b1;
                rsp_o       <= rsp_data_q.pop_front();
                rsp_due_q.delete(0);
            end
            busy_o <= ($urandom_range(3, 0) == 0);
        end
    end

endmodule

/* tb_vram_copy.sv */
// Testbench of the VRAM copy engine that runs directed copies and compares VRAM with a shadow copy
`timescale 1ns/100ps
`include "vram_copy_defines.svh"

module tb_vram_copy;

    localparam int WORDS = 1 << `WORD_ADDR_W;
    localparam int N_RAND = 8;

    logic                      clk_i = 1'b0;
    logic                      rst_i;
    logic                      req_valid_i;
    vram_copy_pkg::copy_req_t  req_i;
    logic                      req_accept_o;
    logic                      busy_o;
    logic                      done_o;
    logic                      mem_cmd_valid_o;
    vram_copy_pkg::mem_cmd_t   mem_cmd_o;
    logic                      mem_busy_i;
    logic                      mem_rsp_valid_i;
    vram_copy_pkg::vram_word_t mem_rsp_i;

    vram_copy_pkg::vram_word_t shadow [WORDS];
    vram_copy_pkg::copy_req_t  rand_reqs [N_RAND];
    longint                    limit_ns;
    bit                        limit_ready = 1'b0;

    always #4 clk_i = ~clk_i;

    vram_copy_top i_dut (
        .clk_i(clk_i), .rst_i(rst_i),
        .req_valid_i(req_valid_i), .req_i(req_i), .req_accept_o(req_accept_o),
        .busy_o(busy_o), .done_o(done_o),
        .mem_cmd_valid_o(mem_cmd_valid_o), .mem_cmd_o(mem_cmd_o), .mem_busy_i(mem_busy_i),
        .mem_rsp_valid_i(mem_rsp_valid_i), .mem_rsp_i(mem_rsp_i)
    );

    tb_vram_model i_mem (
        .clk_i(clk_i), .rst_i(rst_i),
        .cmd_valid_i(mem_cmd_valid_o), .cmd_i(mem_cmd_o), .busy_o(mem_busy_i),
        .rsp_valid_o(mem_rsp_valid_i), .rsp_o(mem_rsp_i)
    );

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t %s: got %0b, expected %0b", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "Control output mismatch");
        end
    endtask

    task automatic check_pixel(input int x, input int y, input vram_copy_pkg::pixel_t got,
                               input vram_copy_pkg::pixel_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t pixel(%0d,%0d): got %h, expected %h", $time, x, y, got, exp);
            $display("TEST FAIL");
            $fatal(1, "VRAM pixel mismatch");
        end
    endtask

    task automatic compare_memory();
        vram_copy_pkg::word_addr_t a;
        vram_copy_pkg::pix_idx_t   l;
        for (int w = 0; w < WORDS; w++)
        begin
            a = vram_copy_pkg::word_addr_t'(w);
            for (int p = 0; p < 16; p++)
            begin
                l = vram_copy_pkg::pix_idx_t'(p);
                check_pixel((w % 64) * 16 + p, w / 64, i_mem.mem[a][l], shadow[a][l]);
            end
        end
    endtask

    // ----------------------------------------
    // Shadow VRAM and request helpers
    // ----------------------------------------
    function automatic vram_copy_pkg::word_addr_t pixel_word(input int x, input int y);
        return vram_copy_pkg::word_addr_t'(y * 64 + x / 16);
    endfunction

    function automatic vram_copy_pkg::copy_req_t make_req(input int sx, input int sy,
        input int dx, input int dy, input int w, input int h, input bit set_mask);
        vram_copy_pkg::copy_req_t r;
        r.src_x    = vram_copy_pkg::x_coord_t'(sx);
        r.src_y    = vram_copy_pkg::y_coord_t'(sy);
        r.dst_x    = vram_copy_pkg::x_coord_t'(dx);
        r.dst_y    = vram_copy_pkg::y_coord_t'(dy);
        r.width    = 11'(w);
        r.height   = 10'(h);
        r.set_mask = set_mask;
        return r;
    endfunction

    // Every destination pixel takes its source pixel with bit 15 forced under set-mask
    task automatic apply_copy_rule(input vram_copy_pkg::copy_req_t r);
        vram_copy_pkg::pixel_t p;
        int sx;
        int sy;
        int dx;
        int dy;
        for (int row = 0; row < int'(r.height); row++)
        begin
            for (int col = 0; col < int'(r.width); col++)
            begin
                sx = int'(r.src_x) + col;
                sy = int'(r.src_y) + row;
                dx = int'(r.dst_x) + col;
                dy = int'(r.dst_y) + row;
                p  = shadow[pixel_word(sx, sy)][vram_copy_pkg::pix_idx_t'(sx % 16)];
                if (r.set_mask)
                    p[`MASK_BIT] = 1'b1;
                shadow[pixel_word(dx, dy)][vram_copy_pkg::pix_idx_t'(dx % 16)] = p;
            end
        end
    endtask

    task automatic preload_memory();
        vram_copy_pkg::vram_word_t w;
        for (int a = 0; a < WORDS; a++)
        begin
            for (int l = 0; l < 16; l++)
                w[vram_copy_pkg::pix_idx_t'(l)] = vram_copy_pkg::pixel_t'($urandom);
            i_mem.mem[vram_copy_pkg::word_addr_t'(a)] = w;
            shadow[vram_copy_pkg::word_addr_t'(a)]    = w;
        end
    endtask

    // Sources in the upper half and destinations in the lower half never overlap
    task automatic build_random_reqs();
        int w;
        int h;
        for (int i = 0; i < N_RAND; i++)
        begin
            w = int'($urandom_range(64, 1));
            h = int'($urandom_range(8, 1));
            rand_reqs[i] = make_req(int'($urandom_range(1024 - w, 0)),
                                    int'($urandom_range(256 - h, 0)),
                                    int'($urandom_range(1024 - w, 0)),
                                    256 + int'($urandom_range(256 - h, 0)),
                                    w, h, bit'($urandom_range(1, 0)));
        end
    endtask

    // Issues one request and follows busy, accept and done until the copy ends
    task automatic copy_and_check(input vram_copy_pkg::copy_req_t r);
        bit finished;
        apply_copy_rule(r);
        @(posedge clk_i);
        req_valid_i <= 1'b1;
        req_i       <= r;
        @(posedge clk_i);
        req_valid_i <= 1'b0;
        finished = 1'b0;
        while (!finished)
        begin
            @(negedge clk_i);
            check_flag("busy_o", busy_o, 1'b1);
            check_flag("req_accept_o", req_accept_o, 1'b0);
            if (done_o)
            begin
                compare_memory();
                finished = 1'b1;
            end
        end
        @(negedge clk_i);
        check_flag("done_o", done_o, 1'b0);
        check_flag("busy_o", busy_o, 1'b0);
        check_flag("req_accept_o", req_accept_o, 1'b1);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset_state();
        @(negedge clk_i);
        check_flag("req_accept_o", req_accept_o, 1'b1);
        check_flag("busy_o", busy_o, 1'b0);
        check_flag("done_o", done_o, 1'b0);
        check_flag("mem_cmd_valid_o", mem_cmd_valid_o, 1'b0);
    endtask

    task automatic test_aligned_copy();
        copy_and_check(make_req(64, 10, 128, 20, 16, 2, 1'b0));
    endtask

    task automatic test_unaligned_copy();
        copy_and_check(make_req(5, 40, 37, 50, 40, 3, 1'b1));
    endtask

    task automatic test_random_copies();
        for (int i = 0; i < N_RAND; i++)
            copy_and_check(rand_reqs[i]);
    endtask

    // Limit from the pixel count of every test
    initial
    begin
        wait (limit_ready);
        #(limit_ns);
        $display("Watchdog expired, the copies did not finish in time");
        $display("TEST FAIL");
        $fatal(1, "Timeout");
    end

    initial
    begin
        longint total_pix;
        void'($urandom(32'hd6a7));
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        build_random_reqs();
        total_pix = 16 * 2 + 40 * 3;
        for (int i = 0; i < N_RAND; i++)
            total_pix += longint'(rand_reqs[i].width) * longint'(rand_reqs[i].height);
        limit_ns    = total_pix * 30 * 8 + 10000;
        limit_ready = 1'b1;
        preload_memory();
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        test_reset_state();
        test_aligned_copy();
        test_unaligned_copy();
        test_random_copies();
        $display("TEST PASS");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
vram_copy_pkg.sv
copy_fifo.sv
vram_copy_read_gen.sv
vram_copy_unroll.sv
vram_copy_reroll.sv
vram_copy_port.sv
vram_copy_top.sv
tb_vram_model.sv
tb_vram_copy.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= tb_vram_copy
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run passes only when the testbench prints its pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
